//--- src/axi_wpath_pkg.sv
`default_nettype none

package axi_wpath_pkg;

  // Address arbiter states.
  typedef enum logic [1:0] {
    ARB_IDLE  = 2'b00,
    ARB_OFFER = 2'b01,
    ARB_HOLD  = 2'b10
  } arb_state_e;

  // AXI write response codes.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } bresp_e;

endpackage

`default_nettype wire

//--- src/wsel_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module wsel_fifo #(
  parameter int num_masters    = 3,
  parameter int fifo_depth_log = 2
) (
  input  wire                            aclk,
  input  wire                            arst_n,
  input  wire                            push,
  input  wire  [$clog2(num_masters)-1:0] push_sel,
  input  wire                            pop,
  output logic [$clog2(num_masters)-1:0] head_sel,
  output logic                           nonempty,
  output logic                           full
);

  localparam int sel_w = $clog2(num_masters);
  localparam int depth = 1 << fifo_depth_log;

  logic [sel_w-1:0]          mem [depth];
  logic [fifo_depth_log-1:0] wr_ptr;
  logic [fifo_depth_log-1:0] rd_ptr;
  logic [fifo_depth_log:0]   count;

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= push_sel;
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the level unchanged.
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  assign head_sel = mem[rd_ptr];
  assign nonempty = (count != '0);
  assign full     = (count == depth[fifo_depth_log:0]);

  no_push_when_full: assert property (
    @(posedge aclk) disable iff (!arst_n) push |-> !full
  ) else $error("push into a full select FIFO");

  no_pop_when_empty: assert property (
    @(posedge aclk) disable iff (!arst_n) pop |-> nonempty
  ) else $error("pop from an empty select FIFO");

endmodule

`default_nettype wire

//--- src/aw_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module aw_arbiter #(
  parameter int num_masters = 3,
  parameter int addr_w      = 32
) (
  input  wire                            aclk,
  input  wire                            arst_n,
  input  wire  [num_masters*addr_w-1:0]  s_awaddr,
  input  wire  [num_masters-1:0]         s_awvalid,
  output logic [num_masters-1:0]         s_awready,
  output logic [addr_w-1:0]              m_awaddr,
  output logic                           m_awvalid,
  input  wire                            m_awready,
  input  wire                            wfifo_full,
  input  wire                            bfifo_full,
  output logic                           push,
  output logic [$clog2(num_masters)-1:0] push_sel
);

  localparam int sel_w = $clog2(num_masters);

  axi_wpath_pkg::arb_state_e state;
  logic [sel_w-1:0]          last_grant;
  logic [sel_w-1:0]          next_grant;
  logic                      found;

  // Round-robin search, starting one past the last winner.
  always_comb begin
    int idx;
    found = 1'b0;
    next_grant = last_grant;
    for (int i = 1; i <= num_masters; i++) begin
      idx = int'(last_grant) + i;
      if (idx >= num_masters) begin
        idx = idx - num_masters;
      end
      if (!found && s_awvalid[idx]) begin
        found = 1'b1;
        next_grant = idx[sel_w-1:0];
      end
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= axi_wpath_pkg::ARB_IDLE;
      // Search starts at master 0 after reset.
      last_grant <= sel_w'(num_masters - 1);
    end else begin
      case (state)
        axi_wpath_pkg::ARB_IDLE: begin
          if (found && !wfifo_full && !bfifo_full) begin
            last_grant <= next_grant;
            state <= axi_wpath_pkg::ARB_OFFER;
          end
        end
        axi_wpath_pkg::ARB_OFFER: begin
          state <= axi_wpath_pkg::ARB_HOLD;
        end
        axi_wpath_pkg::ARB_HOLD: begin
          if (m_awready) begin
            state <= axi_wpath_pkg::ARB_IDLE;
          end
        end
        default: begin
          state <= axi_wpath_pkg::ARB_IDLE;
        end
      endcase
    end
  end

  // Address is taken from the winner while its s_awready pulses.
  always_ff @(posedge aclk) begin
    if (state == axi_wpath_pkg::ARB_OFFER) begin
      m_awaddr <= s_awaddr[last_grant*addr_w +: addr_w];
    end
  end

  always_comb begin
    s_awready = '0;
    if (state == axi_wpath_pkg::ARB_OFFER) begin
      s_awready[last_grant] = 1'b1;
    end
  end

  assign m_awvalid = (state == axi_wpath_pkg::ARB_HOLD);
  assign push      = m_awvalid & m_awready;
  assign push_sel  = last_grant;

  aw_stable_until_ready: assert property (
    @(posedge aclk) disable iff (!arst_n)
    m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr)
  ) else $error("m_awvalid or m_awaddr changed before the AW transfer");

endmodule

`default_nettype wire

//--- src/wdata_mux.sv
`timescale 1ns/100ps
`default_nettype none

module wdata_mux #(
  parameter int num_masters = 3,
  parameter int data_w      = 32
) (
  input  wire  [num_masters*data_w-1:0]  s_wdata,
  input  wire  [num_masters-1:0]         s_wlast,
  input  wire  [num_masters-1:0]         s_wvalid,
  output logic [num_masters-1:0]         s_wready,
  output logic [data_w-1:0]              m_wdata,
  output logic                           m_wlast,
  output logic                           m_wvalid,
  input  wire                            m_wready,
  input  wire  [$clog2(num_masters)-1:0] head_sel,
  input  wire                            nonempty,
  output logic                           pop
);

  logic [num_masters-1:0] sel_hot;
  logic [data_w-1:0]      wdata_sel;
  logic                   valid_sel;

  // One-hot decode of the head index and AND-OR data select.
  always_comb begin
    sel_hot = '0;
    wdata_sel = '0;
    for (int i = 0; i < num_masters; i++) begin
      sel_hot[i] = (head_sel == i);
      wdata_sel = wdata_sel | (s_wdata[i*data_w +: data_w] & {data_w{sel_hot[i]}});
    end
  end

  assign valid_sel = |(s_wvalid & sel_hot);

  assign m_wdata  = wdata_sel;
  assign m_wlast  = |(s_wlast & sel_hot);
  // Beats wait at the master until its burst is at the FIFO head.
  assign m_wvalid = valid_sel & nonempty;
  assign s_wready = sel_hot & {num_masters{nonempty & m_wready}};
  // Release the head entry when the last beat transfers.
  assign pop      = m_wvalid & m_wready & m_wlast;

  wvalid_needs_head: assert final (!m_wvalid || nonempty)
    else $error("m_wvalid without a select FIFO entry");

  wready_onehot: assert final ($onehot0(s_wready))
    else $error("more than one s_wready bit high");

endmodule

`default_nettype wire

//--- src/bresp_demux.sv
`timescale 1ns/100ps
`default_nettype none

module bresp_demux #(
  parameter int num_masters = 3
) (
  input  wire axi_wpath_pkg::bresp_e     m_bresp,
  input  wire                            m_bvalid,
  output logic                           m_bready,
  output logic [num_masters*2-1:0]       s_bresp,
  output logic [num_masters-1:0]         s_bvalid,
  input  wire  [num_masters-1:0]         s_bready,
  input  wire  [$clog2(num_masters)-1:0] head_sel,
  input  wire                            nonempty,
  output logic                           pop
);

  logic [num_masters-1:0] sel_hot;

  always_comb begin
    for (int i = 0; i < num_masters; i++) begin
      sel_hot[i] = (head_sel == i);
    end
  end

  // The response code goes to every master and only the owner sees valid.
  assign s_bresp  = {num_masters{m_bresp}};
  assign s_bvalid = sel_hot & {num_masters{m_bvalid & nonempty}};
  assign m_bready = |(s_bready & sel_hot) & nonempty;
  assign pop      = m_bvalid & m_bready;

  bvalid_onehot: assert final ($onehot0(s_bvalid))
    else $error("more than one s_bvalid bit high");

endmodule

`default_nettype wire

//--- src/axi_wpath_top.sv
`timescale 1ns/100ps
`default_nettype none

module axi_wpath_top #(
  parameter int num_masters    = 3,
  parameter int data_w         = 32,
  parameter int addr_w         = 32,
  parameter int fifo_depth_log = 2
) (
  input  wire                           aclk,
  input  wire                           arst_n,
  input  wire  [num_masters*addr_w-1:0] s_awaddr,
  input  wire  [num_masters-1:0]        s_awvalid,
  output wire  [num_masters-1:0]        s_awready,
  input  wire  [num_masters*data_w-1:0] s_wdata,
  input  wire  [num_masters-1:0]        s_wlast,
  input  wire  [num_masters-1:0]        s_wvalid,
  output wire  [num_masters-1:0]        s_wready,
  output wire  [num_masters*2-1:0]      s_bresp,
  output wire  [num_masters-1:0]        s_bvalid,
  input  wire  [num_masters-1:0]        s_bready,
  output wire  [addr_w-1:0]             m_awaddr,
  output wire                           m_awvalid,
  input  wire                           m_awready,
  output wire  [data_w-1:0]             m_wdata,
  output wire                           m_wlast,
  output wire                           m_wvalid,
  input  wire                           m_wready,
  input  wire axi_wpath_pkg::bresp_e    m_bresp,
  input  wire                           m_bvalid,
  output wire                           m_bready
);

  localparam int sel_w = $clog2(num_masters);

  wire             push;
  wire [sel_w-1:0] push_sel;
  wire             wfifo_full;
  wire             bfifo_full;
  wire [sel_w-1:0] wfifo_head;
  wire             wfifo_nonempty;
  wire             wfifo_pop;
  wire [sel_w-1:0] bfifo_head;
  wire             bfifo_nonempty;
  wire             bfifo_pop;

  aw_arbiter #(.num_masters(num_masters), .addr_w(addr_w)) u_arb (
    .aclk(aclk), .arst_n(arst_n),
    .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
    .m_awaddr(m_awaddr), .m_awvalid(m_awvalid), .m_awready(m_awready),
    .wfifo_full(wfifo_full), .bfifo_full(bfifo_full),
    .push(push), .push_sel(push_sel)
  );

  // W order and B order both follow AW transfer order.
  wsel_fifo #(.num_masters(num_masters), .fifo_depth_log(fifo_depth_log)) u_wfifo (
    .aclk(aclk), .arst_n(arst_n), .push(push), .push_sel(push_sel), .pop(wfifo_pop),
    .head_sel(wfifo_head), .nonempty(wfifo_nonempty), .full(wfifo_full)
  );

  wsel_fifo #(.num_masters(num_masters), .fifo_depth_log(fifo_depth_log)) u_bfifo (
    .aclk(aclk), .arst_n(arst_n), .push(push), .push_sel(push_sel), .pop(bfifo_pop),
    .head_sel(bfifo_head), .nonempty(bfifo_nonempty), .full(bfifo_full)
  );

  wdata_mux #(.num_masters(num_masters), .data_w(data_w)) u_wmux (
    .s_wdata(s_wdata), .s_wlast(s_wlast), .s_wvalid(s_wvalid), .s_wready(s_wready),
    .m_wdata(m_wdata), .m_wlast(m_wlast), .m_wvalid(m_wvalid), .m_wready(m_wready),
    .head_sel(wfifo_head), .nonempty(wfifo_nonempty), .pop(wfifo_pop)
  );

  bresp_demux #(.num_masters(num_masters)) u_bdemux (
    .m_bresp(m_bresp), .m_bvalid(m_bvalid), .m_bready(m_bready),
    .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
    .head_sel(bfifo_head), .nonempty(bfifo_nonempty), .pop(bfifo_pop)
  );

endmodule

`default_nettype wire

//--- testbench/tb_axi_wpath.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axi_wpath;

  localparam int num_masters = 3;
  localparam int data_w      = 32;
  localparam int addr_w      = 32;
  localparam int max_bursts  = 8;
  // About 45 bursts of up to 4 beats in all, with random stalls on AW, W and B.
  localparam int cycle_limit = 4000;

  logic                          aclk;
  logic                          arst_n;
  logic [num_masters*addr_w-1:0] s_awaddr;
  logic [num_masters*data_w-1:0] s_wdata;
  logic [num_masters-1:0]        s_awvalid, s_wlast, s_wvalid, s_bready;
  logic [num_masters-1:0]        s_awready, s_wready, s_bvalid;
  logic [num_masters*2-1:0]      s_bresp;
  logic [addr_w-1:0]             m_awaddr;
  logic [data_w-1:0]             m_wdata;
  logic                          m_awvalid, m_awready, m_wlast, m_wvalid, m_wready;
  logic                          m_bvalid, m_bready;
  axi_wpath_pkg::bresp_e         m_bresp;

  // Master and slave model state.
  int         nb [num_masters];
  int         blen [num_masters][max_bursts];
  int         aw_idx [num_masters];
  int         w_burst [num_masters];
  int         w_beat [num_masters];
  logic [1:0] b_code_q [$];
  logic       aw_bp, w_bp, b_bp;

  // Expected transfers.
  logic [32:0]            w_exp [$];
  int                     b_own [$];
  int                     gcount [num_masters];
  int                     last_ref, pending, prev_pending, b_done;
  logic [num_masters-1:0] prev_mask;
  int                     errors = 0;
  int                     tests_run = 0;
  int                     tests_bad = 0;
  int                     cycles = 0;

  axi_wpath_top #(
    .num_masters(num_masters), .data_w(data_w), .addr_w(addr_w), .fifo_depth_log(2)
  ) UUT (.*);

  function automatic logic [31:0] addr_of(int m, int k);
    return {4'(m), 12'h000, 16'(k)};
  endfunction

  function automatic logic [31:0] data_of(int m, int k, int b);
    return {8'(m), 16'(k), 8'(b)};
  endfunction

  // The next winner is the first requester above the last one with wrap-around.
  function automatic int rr_next(logic [num_masters-1:0] mask, int last);
    int idx;
    for (int i = 1; i <= num_masters; i++) begin
      idx = (last + i) % num_masters;
      if (mask[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  task automatic report_value(string name, logic [63:0] got, logic [63:0] exp);
    $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_error(string msg);
    $display("ERROR t=%0t %s", $time, msg);
    errors++;
  endtask

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Run stopped at the cycle limit of %0d with transfers pending", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  // Masters present their W beats at once, before their addresses win.
  task automatic run_models();
    logic [num_masters-1:0] aw_hs;
    logic [num_masters-1:0] w_hs;
    logic                   b_hs;
    logic                   w_end;
    forever begin
      @(negedge aclk);
      aw_hs = s_awvalid & s_awready;
      w_hs = s_wvalid & s_wready;
      b_hs = m_bvalid & m_bready;
      w_end = m_wvalid & m_wready & m_wlast;
      @(posedge aclk);
      #1;
      if (!arst_n) begin
        b_code_q.delete();
      end
      for (int m = 0; m < num_masters; m++) begin
        if (!arst_n) begin
          aw_idx[m] = 0;
          w_burst[m] = 0;
          w_beat[m] = 0;
        end else begin
          if (aw_hs[m]) begin
            aw_idx[m]++;
          end
          if (w_hs[m]) begin
            w_beat[m]++;
            if (w_beat[m] == blen[m][w_burst[m]]) begin
              w_beat[m] = 0;
              w_burst[m]++;
            end
          end
        end
        s_awvalid[m] = aw_idx[m] < nb[m];
        s_awaddr[m*addr_w +: addr_w] = addr_of(m, aw_idx[m]);
        s_wvalid[m] = w_burst[m] < nb[m];
        s_wdata[m*data_w +: data_w] = data_of(m, w_burst[m], w_beat[m]);
        s_wlast[m] = s_wvalid[m] && (w_beat[m] == blen[m][w_burst[m]] - 1);
      end
      if (b_hs) begin
        void'(b_code_q.pop_front());
      end
      if (w_end) begin
        b_code_q.push_back(2'($urandom % 4));
      end
      m_awready = aw_bp ? 1'($urandom % 2) : 1'b1;
      m_wready = w_bp ? 1'($urandom % 2) : 1'b1;
      s_bready = b_bp ? num_masters'($urandom) : '1;
      m_bvalid = b_code_q.size() > 0;
      m_bresp = axi_wpath_pkg::bresp_e'(b_code_q.size() > 0 ? b_code_q[0] : 2'b00);
    end
  endtask

  task automatic compare_transfers();
    int          g;
    int          m;
    int          exp_m;
    int          exp_k;
    logic [32:0] beat;
    forever begin
      @(negedge aclk);
      if (!arst_n) begin
        w_exp.delete();
        b_own.delete();
        for (int i = 0; i < num_masters; i++) begin
          gcount[i] = 0;
        end
        last_ref = num_masters - 1;
        pending = 0;
        prev_pending = 0;
        b_done = 0;
        prev_mask = '0;
      end else begin
        // A grant shows one cycle after the requests it was chosen from.
        if (s_awready != '0) begin
          g = rr_next(prev_mask, last_ref);
          if (g < 0) begin
            report_error("s_awready raised with no request pending");
          end else begin
            if (s_awready != (1 << g)) begin
              report_value("s_awready", s_awready, 1 << g);
            end
            if (prev_pending >= 4) begin
              report_error("address accepted while four bursts were unfinished");
            end
            last_ref = g;
            exp_m = g;
            exp_k = gcount[g];
            gcount[g]++;
          end
        end
        prev_pending = pending;
        prev_mask = s_awvalid;
        if (m_awvalid && m_awready) begin
          if (m_awaddr !== addr_of(exp_m, exp_k)) begin
            report_value("m_awaddr", m_awaddr, addr_of(exp_m, exp_k));
          end
          for (int b = 0; b < blen[exp_m][exp_k]; b++) begin
            w_exp.push_back({b == blen[exp_m][exp_k] - 1, data_of(exp_m, exp_k, b)});
          end
          b_own.push_back(exp_m);
          pending++;
        end
        if (m_wvalid && m_wready) begin
          if (w_exp.size() == 0) begin
            report_error("W beat arrived with no burst expected");
          end else begin
            beat = w_exp.pop_front();
            if (m_wdata !== beat[31:0]) begin
              report_value("m_wdata", m_wdata, beat[31:0]);
            end
            if (m_wlast !== beat[32]) begin
              report_value("m_wlast", m_wlast, beat[32]);
            end
          end
        end
        if (m_bvalid && m_bready) begin
          if (b_own.size() == 0) begin
            report_error("B response arrived with no burst outstanding");
          end else begin
            m = b_own.pop_front();
            if (s_bvalid !== (1 << m)) begin
              report_value("s_bvalid", s_bvalid, 1 << m);
            end
            // A response transfers only while its owner is ready.
            if (s_bready[m] !== 1'b1) begin
              report_value("m_bready", m_bready, s_bready[m]);
            end
            if (s_bresp[m*2 +: 2] !== b_code_q[0]) begin
              report_value("s_bresp", s_bresp[m*2 +: 2], b_code_q[0]);
            end
          end
          pending--;
          b_done++;
        end
      end
    end
  endtask

  task automatic setup_test(int n0, int n1, int n2, logic awbp, logic wbp, logic bbp);
    @(posedge aclk);
    #1;
    arst_n = 1'b0;
    nb[0] = n0;
    nb[1] = n1;
    nb[2] = n2;
    aw_bp = awbp;
    w_bp = wbp;
    b_bp = bbp;
    for (int m = 0; m < num_masters; m++) begin
      for (int k = 0; k < max_bursts; k++) begin
        blen[m][k] = 1 + int'($urandom % 4);
      end
    end
    repeat (2) @(posedge aclk);
    #1;
    arst_n = 1'b1;
  endtask

  task automatic finish_test(string name, int total, int err0);
    while (b_done < total) begin
      @(posedge aclk);
    end
    @(posedge aclk);
    if (w_exp.size() != 0 || b_own.size() != 0) begin
      report_error("transfers left over after the last response");
    end
    if (errors == err0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, errors - err0);
      tests_bad++;
    end
    tests_run++;
  endtask

  initial begin
    int err0;
    void'($urandom(17155));
    arst_n = 1'b0;
    s_awaddr = '0;
    s_awvalid = '0;
    s_wdata = '0;
    s_wlast = '0;
    s_wvalid = '0;
    s_bready = '0;
    m_awready = 1'b0;
    m_wready = 1'b0;
    m_bvalid = 1'b0;
    m_bresp = axi_wpath_pkg::RESP_OKAY;
    aw_bp = 1'b0;
    w_bp = 1'b0;
    b_bp = 1'b0;
    fork
      run_models();
      compare_transfers();
    join_none

    err0 = errors;
    setup_test(0, 1, 0, 1'b0, 1'b0, 1'b0);
    @(negedge aclk);
    if (m_awvalid !== 1'b0) report_value("m_awvalid", m_awvalid, 0);
    if (m_wvalid !== 1'b0) report_value("m_wvalid", m_wvalid, 0);
    if (m_bready !== 1'b0) report_value("m_bready", m_bready, 0);
    if (s_awready !== '0) report_value("s_awready", s_awready, 0);
    if (s_wready !== '0) report_value("s_wready", s_wready, 0);
    if (s_bvalid !== '0) report_value("s_bvalid", s_bvalid, 0);
    finish_test("1 reset and single burst", 1, err0);

    err0 = errors;
    setup_test(4, 4, 4, 1'b0, 1'b0, 1'b0);
    finish_test("2 round-robin order", 12, err0);

    err0 = errors;
    setup_test(2, 2, 2, 1'b1, 1'b0, 1'b0);
    finish_test("3 early W beats", 6, err0);

    err0 = errors;
    setup_test(6, 5, 5, 1'b1, 1'b1, 1'b0);
    finish_test("4 back-pressure and full FIFO", 16, err0);

    err0 = errors;
    setup_test(3, 3, 3, 1'b1, 1'b1, 1'b1);
    finish_test("5 response routing", 9, err0);

    $display("Summary: %0d tests, %0d with errors, %0d check errors",
             tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- axi_wpath.f
src/axi_wpath_pkg.sv
src/wsel_fifo.sv
src/aw_arbiter.sv
src/wdata_mux.sv
src/bresp_demux.sv
src/axi_wpath_top.sv
testbench/tb_axi_wpath.sv
